// ==== hdl/pram_if.sv ====
`timescale 1ns/1ns
`include "pram_macros.svh"

module pram_if (
  input  logic                 sys_clk,
  input  logic                 sys_rst,
  input  logic                 mcu_hold,
  input  logic                 prog_mode,
  input  logic                 rab_write,
  input  logic                 rab_read,
  input  pram_pkg::rab_addr_t  rab_addr,
  input  pram_pkg::byte_t      rab_wdata,
  output pram_pkg::byte_t      loader_rdata,
  output logic                 loader_ack,
  input  pram_pkg::byte_t      pram_rdata,
  output logic                 pram_wen,
  output logic                 pram_cen,
  output pram_pkg::pram_addr_t pram_addr,
  output pram_pkg::byte_t      pram_wdata,
  input  pram_pkg::pram_addr_t memaddr,
  input  logic                 mempsrd,
  output pram_pkg::byte_t      romdata,
  output logic                 mempsrd_d
);

  pram_pkg::byte_t      prog_addr_h;
  pram_pkg::byte_t      prog_addr_l;
  pram_pkg::byte_t      prog_data;
  pram_pkg::pram_addr_t ramaddr;
  logic                 wr_1st_flag;
  logic                 prog_ram_wr;
  logic                 prog_ram_rd;
  logic                 prog_ram_rd_d;

  logic hit_h;
  logic hit_l;
  logic hit_d;
  logic set_l;
  logic wr_data_stb;
  logic rd_data_stb;

  // register decode
  assign hit_h = (rab_addr == `PRAM_REG_ADDR_H);
  assign hit_l = (rab_addr == `PRAM_REG_ADDR_L);
  assign hit_d = (rab_addr == `PRAM_REG_DATA);

  assign set_l       = rab_write & hit_l;
  // data window strobes, qualified by the loader mode
  assign wr_data_stb = rab_write & hit_d & ~prog_mode;
  assign rd_data_stb = rab_read & hit_d & prog_mode;

  // RAM port goes to the fetch bus once the MCU is released
  assign pram_addr  = mcu_hold ? ramaddr : memaddr;
  assign pram_cen   = mcu_hold ? ~(prog_ram_wr | prog_ram_rd) : mempsrd;
  assign pram_wen   = mcu_hold ? ~prog_ram_wr : 1'b1;
  assign pram_wdata = prog_data;

  // nothing is stored above 16 KB
  assign romdata = (memaddr[15:`PRAM_AW] == '0) ? pram_rdata : 8'h00;

  always_ff @(posedge sys_clk or posedge sys_rst) begin
    if (sys_rst) begin
      prog_addr_h <= 8'h00;
      prog_addr_l <= 8'h00;
    end else if (rab_write && hit_h) begin
      prog_addr_h <= rab_wdata;
    end else if (set_l) begin
      prog_addr_l <= rab_wdata;
    end
  end

  // write buffer in write mode, prefetch holder in read mode
  always_ff @(posedge sys_clk) begin
    if (prog_ram_rd_d) begin
      prog_data <= pram_rdata;
    end else if (wr_data_stb) begin
      prog_data <= rab_wdata;
    end
  end

  // first data write after a low byte starts at the loaded address
  always_ff @(posedge sys_clk or posedge sys_rst) begin
    if (sys_rst) begin
      wr_1st_flag <= 1'b0;
    end else if (set_l && !prog_mode) begin
      wr_1st_flag <= 1'b1;
    end else if (wr_data_stb) begin
      wr_1st_flag <= 1'b0;
    end
  end

  always_ff @(posedge sys_clk or posedge sys_rst) begin
    if (sys_rst) begin
      ramaddr <= 16'h0000;
    end else if (set_l && prog_mode) begin
      // prefetch starts from the incoming low byte
      ramaddr <= {prog_addr_h, rab_wdata};
    end else if (wr_data_stb) begin
      ramaddr <= wr_1st_flag ? {prog_addr_h, prog_addr_l} : ramaddr + 16'd1;
    end else if (rd_data_stb) begin
      ramaddr <= ramaddr + 16'd1;
    end
  end

  // one-cycle RAM access pulses, only while the host owns the port
  always_ff @(posedge sys_clk or posedge sys_rst) begin
    if (sys_rst) begin
      prog_ram_wr   <= 1'b0;
      prog_ram_rd   <= 1'b0;
      prog_ram_rd_d <= 1'b0;
    end else begin
      prog_ram_wr   <= wr_data_stb & mcu_hold;
      prog_ram_rd   <= ((set_l & prog_mode) | rd_data_stb) & mcu_hold;
      prog_ram_rd_d <= prog_ram_rd;
    end
  end

  // host read data and ack
  always_ff @(posedge sys_clk or posedge sys_rst) begin
    if (sys_rst) begin
      loader_rdata <= 8'h00;
      loader_ack   <= 1'b0;
    end else begin
      loader_ack <= (rab_write | rab_read) & (hit_h | hit_l | hit_d);
      if (rab_read && hit_h) begin
        loader_rdata <= prog_addr_h;
      end else if (rab_read && hit_l) begin
        loader_rdata <= prog_addr_l;
      end else if (rab_read && hit_d) begin
        loader_rdata <= prog_data;
      end
    end
  end

  // fetch strobe sampled on the falling edge
  always_ff @(negedge sys_clk or posedge sys_rst) begin
    if (sys_rst) begin
      mempsrd_d <= 1'b1;
    end else begin
      mempsrd_d <= mempsrd;
    end
  end

endmodule

// ==== hdl/pram_loader_top.sv ====
`timescale 1ns/1ns

module pram_loader_top (
  input  logic                 sys_clk,
  input  logic                 sys_rst,
  input  logic                 rab_write,
  input  logic                 rab_read,
  input  pram_pkg::rab_addr_t  rab_addr,
  input  pram_pkg::byte_t      rab_wdata,
  output pram_pkg::byte_t      rab_rdata,
  output logic                 rab_ack,
  input  pram_pkg::pram_addr_t memaddr,
  input  logic                 mempsrd,
  output pram_pkg::byte_t      romdata,
  output logic                 mempsrd_d
);

  logic                 mcu_hold;
  logic                 prog_mode;
  pram_pkg::byte_t      loader_rdata;
  logic                 loader_ack;
  logic                 pram_cen;
  logic                 pram_wen;
  pram_pkg::pram_addr_t pram_addr;
  pram_pkg::byte_t      pram_wdata;
  pram_pkg::byte_t      pram_rdata;

  rab_ctrl_regs u_rab_ctrl_regs (
    .sys_clk      (sys_clk),
    .sys_rst      (sys_rst),
    .rab_write    (rab_write),
    .rab_read     (rab_read),
    .rab_addr     (rab_addr),
    .rab_wdata    (rab_wdata),
    .mcu_hold     (mcu_hold),
    .prog_mode    (prog_mode),
    .loader_rdata (loader_rdata),
    .loader_ack   (loader_ack),
    .rab_rdata    (rab_rdata),
    .rab_ack      (rab_ack)
  );

  pram_if u_pram_if (
    .sys_clk      (sys_clk),
    .sys_rst      (sys_rst),
    .mcu_hold     (mcu_hold),
    .prog_mode    (prog_mode),
    .rab_write    (rab_write),
    .rab_read     (rab_read),
    .rab_addr     (rab_addr),
    .rab_wdata    (rab_wdata),
    .loader_rdata (loader_rdata),
    .loader_ack   (loader_ack),
    .pram_rdata   (pram_rdata),
    .pram_wen     (pram_wen),
    .pram_cen     (pram_cen),
    .pram_addr    (pram_addr),
    .pram_wdata   (pram_wdata),
    .memaddr      (memaddr),
    .mempsrd      (mempsrd),
    .romdata      (romdata),
    .mempsrd_d    (mempsrd_d)
  );

  pram_sram u_pram_sram (
    .sys_clk (sys_clk),
    .cen     (pram_cen),
    .wen     (pram_wen),
    .addr    (pram_addr),
    .wdata   (pram_wdata),
    .rdata   (pram_rdata)
  );

endmodule

// ==== hdl/pram_macros.svh ====
`ifndef PRAM_MACROS_SVH
`define PRAM_MACROS_SVH

// host register map, 9-bit register addresses
`define PRAM_REG_CTRL      9'h010
`define PRAM_REG_ADDR_H    9'h01a
`define PRAM_REG_ADDR_L    9'h01b
`define PRAM_REG_DATA      9'h01c

// program RAM size in address bits (16 KB)
`define PRAM_AW            14

// control register bit positions
// hold bit set keeps the MCU in reset and gives the RAM port to the host
`define PRAM_CTRL_HOLD_BIT 0
// mode bit: 0 sequential write, 1 sequential read
`define PRAM_CTRL_MODE_BIT 1

`endif

// ==== hdl/pram_pkg.sv ====
package pram_pkg;

  // one data byte on host bus, RAM and fetch bus
  typedef logic [7:0] byte_t;

  // full 16-bit program address of the MCU
  typedef logic [15:0] pram_addr_t;

  // host register address
  typedef logic [8:0] rab_addr_t;

endpackage

// ==== hdl/pram_sram.sv ====
`timescale 1ns/1ns
`include "pram_macros.svh"

module pram_sram (
  input  logic                 sys_clk,
  input  logic                 cen,
  input  logic                 wen,
  input  pram_pkg::pram_addr_t addr,
  input  pram_pkg::byte_t      wdata,
  output pram_pkg::byte_t      rdata
);

  localparam int DEPTH = 1 << `PRAM_AW;

  pram_pkg::byte_t mem [DEPTH];

  logic [`PRAM_AW-1:0] word_addr;

  // upper address bits are ignored, the array wraps
  assign word_addr = addr[`PRAM_AW-1:0];

  always_ff @(posedge sys_clk) begin
    if (!cen && !wen) begin
      mem[word_addr] <= wdata;
    end
    // registered read, one cycle latency
    if (!cen && wen) begin
      rdata <= mem[word_addr];
    end
  end

endmodule

// ==== hdl/rab_ctrl_regs.sv ====
`timescale 1ns/1ns
`include "pram_macros.svh"

module rab_ctrl_regs (
  input  logic                sys_clk,
  input  logic                sys_rst,
  input  logic                rab_write,
  input  logic                rab_read,
  input  pram_pkg::rab_addr_t rab_addr,
  input  pram_pkg::byte_t     rab_wdata,
  output logic                mcu_hold,
  output logic                prog_mode,
  input  pram_pkg::byte_t     loader_rdata,
  input  logic                loader_ack,
  output pram_pkg::byte_t     rab_rdata,
  output logic                rab_ack
);

  pram_pkg::byte_t ctrl_reg;
  pram_pkg::byte_t ctrl_rdata;
  logic            ctrl_ack;
  logic            ctrl_sel;
  logic            hit_ctrl;

  assign hit_ctrl = (rab_addr == `PRAM_REG_CTRL);

  assign mcu_hold  = ctrl_reg[`PRAM_CTRL_HOLD_BIT];
  assign prog_mode = ctrl_reg[`PRAM_CTRL_MODE_BIT];

  // MCU starts out held in reset, sequential write mode
  always_ff @(posedge sys_clk or posedge sys_rst) begin
    if (sys_rst) begin
      ctrl_reg                      <= 8'h00;
      ctrl_reg[`PRAM_CTRL_HOLD_BIT] <= 1'b1;
    end else if (rab_write && hit_ctrl) begin
      ctrl_reg <= rab_wdata;
    end
  end

  always_ff @(posedge sys_clk or posedge sys_rst) begin
    if (sys_rst) begin
      ctrl_rdata <= 8'h00;
      ctrl_ack   <= 1'b0;
      ctrl_sel   <= 1'b0;
    end else begin
      ctrl_ack <= (rab_write | rab_read) & hit_ctrl;
      if (rab_read) begin
        // remember who answered the last read so the data holds
        ctrl_sel <= hit_ctrl;
      end
      if (rab_read && hit_ctrl) begin
        ctrl_rdata <= ctrl_reg;
      end
    end
  end

  // merge own response with the loader's
  assign rab_rdata = ctrl_sel ? ctrl_rdata : loader_rdata;
  assign rab_ack   = ctrl_ack | loader_ack;

endmodule

// ==== pram_loader.f ====
+incdir+hdl
hdl/pram_pkg.sv
hdl/pram_sram.sv
hdl/rab_ctrl_regs.sv
hdl/pram_if.sv
hdl/pram_loader_top.sv
sim/tb_pram_loader.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the program-RAM loader testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f pram_loader.f \
  --top-module tb_pram_loader -o sim_pram_loader
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

out=$(./obj_dir/sim_pram_loader)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "NO ERRORS"; then
  exit 0
fi
exit 1

// ==== sim/tb_pram_loader.sv ====
`timescale 1ns/1ns
`include "pram_macros.svh"

module tb_pram_loader;

  localparam int CLK_PERIOD = 40;
  localparam int HOST_GAP   = 5;
  localparam int NUM_BYTES  = 16;
  // about 50 host accesses of 5 cycles and 20 fetches of 2 cycles take some 300 cycles
  localparam int TIMEOUT_CYCLES = 4000;

  logic                 sys_clk;
  logic                 sys_rst;
  logic                 rab_write;
  logic                 rab_read;
  pram_pkg::rab_addr_t  rab_addr;
  pram_pkg::byte_t      rab_wdata;
  pram_pkg::byte_t      rab_rdata;
  logic                 rab_ack;
  pram_pkg::pram_addr_t memaddr;
  logic                 mempsrd;
  pram_pkg::byte_t      romdata;
  logic                 mempsrd_d;

  integer          seed = 98075;
  int              value_errs;
  int              other_errs;
  int              cycle_cnt;
  string           test_name;
  logic            mapped_stb;
  logic            ack_due;
  logic            psrd_at_fall;
  pram_pkg::byte_t model [0:(1 << `PRAM_AW) - 1];

  pram_loader_top u_pram_loader_top (
    .sys_clk   (sys_clk),
    .sys_rst   (sys_rst),
    .rab_write (rab_write),
    .rab_read  (rab_read),
    .rab_addr  (rab_addr),
    .rab_wdata (rab_wdata),
    .rab_rdata (rab_rdata),
    .rab_ack   (rab_ack),
    .memaddr   (memaddr),
    .mempsrd   (mempsrd),
    .romdata   (romdata),
    .mempsrd_d (mempsrd_d)
  );

  initial begin
    sys_clk = 1'b0;
    forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
  end

  function automatic logic is_mapped(input pram_pkg::rab_addr_t addr);
    return addr == `PRAM_REG_CTRL || addr == `PRAM_REG_ADDR_H ||
           addr == `PRAM_REG_ADDR_L || addr == `PRAM_REG_DATA;
  endfunction

  task automatic report_mismatch(input string what, input pram_pkg::byte_t exp,
                                 input pram_pkg::byte_t act);
    value_errs++;
    $display("[ERROR] %s %s: expected 0x%02h, actual 0x%02h", test_name, what, exp, act);
  endtask

  task automatic report_failure(input string msg);
    other_errs++;
    $display("%s: %s", test_name, msg);
  endtask

  task automatic check_byte(input string what, input pram_pkg::byte_t exp,
                            input pram_pkg::byte_t act);
    assert (act == exp) else report_mismatch(what, exp, act);
  endtask

  // ack is due one cycle after every mapped strobe and never otherwise
  assign mapped_stb = (rab_write | rab_read) & is_mapped(rab_addr);

  always @(posedge sys_clk) ack_due <= mapped_stb;

  assert property (@(negedge sys_clk) disable iff (sys_rst) rab_ack == ack_due)
    else report_mismatch("rab_ack", {7'b0, ack_due}, {7'b0, rab_ack});

  // mempsrd_d follows mempsrd of the last falling edge
  always @(negedge sys_clk) psrd_at_fall <= mempsrd;

  always @(posedge sys_clk) begin
    if (!sys_rst) begin
      assert (mempsrd_d == psrd_at_fall)
        else report_mismatch("mempsrd_d", {7'b0, psrd_at_fall}, {7'b0, mempsrd_d});
    end
  end

  task automatic host_write(input pram_pkg::rab_addr_t addr, input pram_pkg::byte_t data);
    rab_addr  = addr;
    rab_wdata = data;
    rab_write = 1'b1;
    @(posedge sys_clk);
    #2;
    rab_write = 1'b0;
    repeat (HOST_GAP - 1) begin
      @(posedge sys_clk);
      #2;
    end
  endtask

  task automatic host_read(input pram_pkg::rab_addr_t addr, output pram_pkg::byte_t data);
    rab_addr = addr;
    rab_read = 1'b1;
    @(posedge sys_clk);
    #2;
    rab_read = 1'b0;
    @(negedge sys_clk);
    data = rab_rdata;
    if (is_mapped(addr)) begin
      assert (rab_ack) else report_failure($sformatf("read of 0x%03h got no ack", addr));
    end
    repeat (HOST_GAP - 1) begin
      @(posedge sys_clk);
      #2;
    end
  endtask

  // one fetch cycle from the MCU side with data taken one cycle later
  task automatic fetch_byte(input pram_pkg::pram_addr_t addr, output pram_pkg::byte_t data);
    memaddr = addr;
    mempsrd = 1'b0;
    @(posedge sys_clk);
    #2;
    mempsrd = 1'b1;
    @(negedge sys_clk);
    data = romdata;
    @(posedge sys_clk);
    #2;
  endtask

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge sys_clk);
      cycle_cnt++;
    end
    $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("value errors: %0d, other errors: %0d", value_errs, other_errs + 1);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    pram_pkg::pram_addr_t base;
    pram_pkg::pram_addr_t addr;
    pram_pkg::byte_t      got;
    pram_pkg::byte_t      wr_byte;
    logic [31:0]          rnd;

    sys_rst    = 1'b1;
    rab_write  = 1'b0;
    rab_read   = 1'b0;
    rab_addr   = '0;
    rab_wdata  = 8'h00;
    memaddr    = 16'h0000;
    mempsrd    = 1'b1;
    value_errs = 0;
    other_errs = 0;
    test_name  = "reset";
    repeat (8) @(posedge sys_clk);
    #2;
    sys_rst = 1'b0;
    @(posedge sys_clk);
    #2;

    test_name = "reset_values";
    check_byte("rab_ack idle", 8'h00, {7'b0, rab_ack});
    check_byte("pram_cen idle", 8'h01, {7'b0, u_pram_loader_top.pram_cen});
    host_read(`PRAM_REG_CTRL, got);
    check_byte("ctrl", 8'h01, got);
    // the ack assertion expects no ack for unmapped accesses
    host_write(9'h055, 8'ha5);
    host_read(9'h11c, got);

    test_name = "reg_readback";
    rnd = $random(seed);
    host_write(`PRAM_REG_ADDR_H, rnd[7:0]);
    host_write(`PRAM_REG_ADDR_L, rnd[15:8]);
    host_read(`PRAM_REG_ADDR_H, got);
    check_byte("addr_h", rnd[7:0], got);
    host_read(`PRAM_REG_ADDR_L, got);
    check_byte("addr_l", rnd[15:8], got);
    wr_byte = rnd[23:16] | 8'h01;
    host_write(`PRAM_REG_CTRL, wr_byte);
    host_read(`PRAM_REG_CTRL, got);
    check_byte("ctrl", wr_byte, got);
    host_write(`PRAM_REG_CTRL, 8'h01);

    test_name = "seq_write_read";
    rnd  = $random(seed);
    base = {2'b00, rnd[13:0]};
    if (base > 16'h3ff0) begin
      base = 16'h3ff0;
    end
    host_write(`PRAM_REG_ADDR_H, base[15:8]);
    host_write(`PRAM_REG_ADDR_L, base[7:0]);
    for (int i = 0; i < NUM_BYTES; i++) begin
      rnd  = $random(seed);
      addr = base + i[15:0];
      model[addr[`PRAM_AW-1:0]] = rnd[7:0];
      host_write(`PRAM_REG_DATA, rnd[7:0]);
    end
    // hold plus read mode so the low byte write starts the prefetch
    host_write(`PRAM_REG_CTRL, 8'h03);
    host_write(`PRAM_REG_ADDR_H, base[15:8]);
    host_write(`PRAM_REG_ADDR_L, base[7:0]);
    for (int i = 0; i < NUM_BYTES; i++) begin
      addr = base + i[15:0];
      host_read(`PRAM_REG_DATA, got);
      check_byte($sformatf("byte at 0x%04h", addr), model[addr[`PRAM_AW-1:0]], got);
    end

    test_name = "mcu_fetch";
    host_write(`PRAM_REG_CTRL, 8'h00);
    for (int i = 0; i < NUM_BYTES; i++) begin
      addr = base + i[15:0];
      fetch_byte(addr, got);
      check_byte($sformatf("romdata at 0x%04h", addr), model[addr[`PRAM_AW-1:0]], got);
    end
    fetch_byte(base + 16'h4000, got);
    check_byte("romdata above 16 KB", 8'h00, got);
    fetch_byte(16'hffff, got);
    check_byte("romdata at 0xffff", 8'h00, got);

    test_name = "write_while_running";
    // loader address and fetch address both sit on base during the host write
    memaddr = base;
    host_write(`PRAM_REG_ADDR_H, base[15:8]);
    host_write(`PRAM_REG_ADDR_L, base[7:0]);
    host_write(`PRAM_REG_DATA, ~model[base[`PRAM_AW-1:0]]);
    fetch_byte(base, got);
    check_byte("romdata after host write", model[base[`PRAM_AW-1:0]], got);
    repeat (2) @(posedge sys_clk);

    $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
